//--- lsu_top.f
lsu_pkg.sv
agu_stage.sv
mem_stage.sv
wb_stage.sv
apb_ram.sv
lsu_top.sv
tb_lsu_top.sv

//--- tb_lsu_top.sv
`timescale 1ns/1ps

module tb_lsu_top
  import lsu_pkg::*;
();

  localparam int RAM_WORDS = 256;
  localparam int RAM_BYTES = RAM_WORDS * 8;
  localparam int TIMEOUT   = 1000;

  logic       clk;
  logic       rst;
  logic       cmd_valid;
  mem_cmd_t   cmd;
  reg_idx_t   rf_raddr;
  logic       cmd_ready;
  xlen_t      rf_rdata;
  logic       retire_valid;
  mem_to_wb_t retire;

  logic [7:0] ram_m [RAM_BYTES];
  xlen_t      regs_m [32];
  mem_to_wb_t exp_q [$];
  mem_to_wb_t exp_r;
  int         issued;
  int         retired;
  int         mismatch_cnt;
  int         other_cnt;
  logic       abort;
  integer     seed;

  mem_op_t st_ops [4] = '{OP_SB, OP_SH, OP_SW, OP_SD};
  mem_op_t ld_ops [6] = '{OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_LWU};
  mem_op_t all_ops [11] = '{OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU,
                            OP_SB, OP_SH, OP_SW, OP_SD};

  lsu_top lsu_top_inst (
    .clk          (clk),
    .rst          (rst),
    .cmd_valid    (cmd_valid),
    .cmd          (cmd),
    .rf_raddr     (rf_raddr),
    .cmd_ready    (cmd_ready),
    .rf_rdata     (rf_rdata),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  always #10 clk = ~clk;

  // expected retire that also updates the RAM and register models
  function automatic mem_to_wb_t ref_result(input mem_cmd_t c);
    addr_t      a;
    int         nb;
    xlen_t      v;
    logic       is_u;
    mem_to_wb_t r;
    // offset is 12-bit two's complement
    a = c.base + c.offset[10:0] - (c.offset[11] ? 64'd2048 : 64'd0);
    case (c.op)
      OP_LB, OP_LBU, OP_SB: nb = 1;
      OP_LH, OP_LHU, OP_SH: nb = 2;
      OP_LW, OP_LWU, OP_SW: nb = 4;
      default:              nb = 8;
    endcase
    is_u = (c.op == OP_LBU) || (c.op == OP_LHU) || (c.op == OP_LWU);
    r.rd   = c.rd;
    r.we   = 1'b0;
    r.data = '0;
    r.err  = 1'b0;
    if (a >= RAM_BYTES || (a % nb) != 0) begin
      r.err = 1'b1;
    end else if (c.op[3]) begin
      for (int i = 0; i < nb; i++) begin
        ram_m[a + i] = c.wdata[8*i +: 8];
      end
    end else begin
      v = '0;
      for (int i = 0; i < nb; i++) begin
        v[8*i +: 8] = ram_m[a + i];
      end
      if (!is_u && nb < 8 && v[8*nb-1]) begin
        for (int i = 8 * nb; i < 64; i++) begin
          v[i] = 1'b1;
        end
      end
      r.data = v;
      r.we   = (c.rd != '0);
      if (r.we) begin
        regs_m[c.rd] = v;
      end
    end
    return r;
  endfunction

  function automatic mem_cmd_t make_cmd(input mem_op_t op, input xlen_t base,
                                        input int off, input xlen_t wdata,
                                        input int rd);
    mem_cmd_t c;
    c.op     = op;
    c.base   = base;
    c.offset = offset_t'(off);
    c.wdata  = wdata;
    c.rd     = reg_idx_t'(rd);
    return c;
  endfunction

  // runs from just after one rising edge to just after the accepting edge
  task automatic send(input mem_cmd_t c);
    int n;
    if (abort) return;
    exp_q.push_back(ref_result(c));
    issued++;
    cmd_valid <= 1'b1;
    cmd       <= c;
    n = 0;
    @(negedge clk);
    while (!cmd_ready && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!cmd_ready) begin
      $display("timeout: cmd_ready stayed low at %0t", $time);
      other_cnt++;
      abort = 1'b1;
    end
    @(posedge clk);
  endtask

  task automatic drain();
    int n;
    if (abort) return;
    cmd_valid <= 1'b0;
    n = 0;
    while (retired != issued && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (retired != issued) begin
      $display("timeout: %0d of %0d commands retired", retired, issued);
      other_cnt++;
      abort = 1'b1;
    end
    @(posedge clk);
  endtask

  task automatic check_reg(input int idx);
    if (abort) return;
    rf_raddr <= reg_idx_t'(idx);
    @(negedge clk);
    if (rf_rdata !== regs_m[idx]) begin
      $display("mismatch at %0t: x%0d reads %h, expected %h", $time, idx, rf_rdata,
               regs_m[idx]);
      mismatch_cnt++;
    end
    @(posedge clk);
  endtask

  always @(negedge clk) begin
    if (!rst && retire_valid) begin
      if (exp_q.size() == 0) begin
        $display("retire at %0t with no command outstanding", $time);
        other_cnt++;
      end else begin
        exp_r = exp_q.pop_front();
        retired++;
        if (retire !== exp_r) begin
          $display("mismatch at %0t: rd %0d we %b data %h err %b, expected %0d %b %h %b",
                   $time, retire.rd, retire.we, retire.data, retire.err,
                   exp_r.rd, exp_r.we, exp_r.data, exp_r.err);
          mismatch_cnt++;
        end
      end
    end
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    cmd_valid = 1'b0;
    cmd = '0;
    rf_raddr = '0;
    seed = 76;
    issued = 0;
    retired = 0;
    mismatch_cnt = 0;
    other_cnt = 0;
    abort = 1'b0;
    for (int i = 0; i < 32; i++) begin
      regs_m[i] = '0;
    end
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    // fill every word so loads never see unwritten data
    for (int w = 0; w < RAM_WORDS; w++) begin
      send(make_cmd(OP_SD, 64'(w * 8), 0, (64'(w) * 64'h9e37_79b9_7f4a_7c15) ^ 64'h5a3c, 0));
    end

    // stores of each size at each aligned offset
    for (int s = 0; s < 4; s++) begin
      for (int off = 0; off < 8; off += (1 << s)) begin
        send(make_cmd(st_ops[s], 64'((10 + s) * 8), off,
                      {$random(seed), $random(seed)}, 0));
        send(make_cmd(OP_LD, 64'((10 + s) * 8), 0, '0, 3));
      end
    end

    // sign and zero extension
    send(make_cmd(OP_SD, 64'(160), 0, 64'h80f1_7f01_fe7e_8000, 0));
    for (int k = 0; k < 6; k++) begin
      for (int off = 0; off < 8; off += (1 << (k % 3))) begin
        send(make_cmd(ld_ops[k], 64'(160), off, '0, 4 + k));
      end
    end
    drain();
    for (int k = 4; k < 10; k++) begin
      check_reg(k);
    end

    // misaligned and out of range
    send(make_cmd(OP_LD, 64'(240), 0, '0, 7));
    send(make_cmd(OP_LH, 64'(240), 1, '0, 7));
    send(make_cmd(OP_LW, 64'(240), 2, '0, 7));
    send(make_cmd(OP_LD, 64'(240), 4, '0, 7));
    send(make_cmd(OP_SW, 64'(240), 2, 64'hdead_beef_dead_beef, 0));
    send(make_cmd(OP_SH, 64'(240), 3, 64'hdead_beef_dead_beef, 0));
    send(make_cmd(OP_SD, 64'(RAM_BYTES), 0, 64'hdead_beef_dead_beef, 0));
    send(make_cmd(OP_LB, 64'hffff_ffff_ffff_fff0, 0, '0, 7));
    send(make_cmd(OP_SB, 64'(RAM_BYTES - 1), 1, 64'hff, 0));
    send(make_cmd(OP_LD, 64'(240), 0, '0, 8));
    drain();
    check_reg(7);
    check_reg(8);

    // load to x0
    send(make_cmd(OP_LD, 64'(160), 0, '0, 0));
    drain();
    check_reg(0);

    // back-to-back random commands with some word-aligned ones
    for (int i = 0; i < 200; i++) begin
      logic       aligned;
      xlen_t      base;
      int         off;
      aligned = $random(seed) & 1;
      base = 64'($unsigned($random(seed)) % 2200);
      off = $random(seed) % 24;
      if (aligned) begin
        base = base & ~64'h7;
        off = off & ~7;
      end
      send(make_cmd(all_ops[$unsigned($random(seed)) % 11], base, off,
                    {$random(seed), $random(seed)}, $random(seed) & 31));
    end
    drain();
    for (int r = 0; r < 32; r++) begin
      check_reg(r);
    end

    $display("errors: %0d mismatches, %0d other, %0d expected results left",
             mismatch_cnt, other_cnt, exp_q.size());
    if (mismatch_cnt == 0 && other_cnt == 0 && exp_q.size() == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- lsu_top.sv
`timescale 1ns/1ps

module lsu_top
  import lsu_pkg::*;
#(
  parameter int RAM_WORDS   = 256,
  parameter int WAIT_CYCLES = 1
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       cmd_valid,
  input  mem_cmd_t   cmd,
  input  reg_idx_t   rf_raddr,
  output logic       cmd_ready,
  output xlen_t      rf_rdata,
  output logic       retire_valid,
  output mem_to_wb_t retire
);

  logic        agu_valid;
  agu_to_mem_t agu_out;
  logic        mem_allowin;
  logic        wb_valid;
  mem_to_wb_t  wb_in;

  // APB between memory stage and data RAM
  logic        psel;
  logic        penable;
  logic        pwrite;
  addr_t       paddr;
  xlen_t       pwdata;
  strb_t       pstrb;
  xlen_t       prdata;
  logic        pready;
  logic        pslverr;

  agu_stage agu_inst (
    .clk         (clk),
    .rst         (rst),
    .cmd_valid   (cmd_valid),
    .cmd         (cmd),
    .mem_allowin (mem_allowin),
    .cmd_ready   (cmd_ready),
    .agu_valid   (agu_valid),
    .agu_out     (agu_out)
  );

  mem_stage mem_inst (
    .clk         (clk),
    .rst         (rst),
    .agu_valid   (agu_valid),
    .agu_out     (agu_out),
    .mem_allowin (mem_allowin),
    .wb_valid    (wb_valid),
    .wb_in       (wb_in),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .pstrb       (pstrb),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr)
  );

  wb_stage wb_inst (
    .clk          (clk),
    .rst          (rst),
    .wb_valid     (wb_valid),
    .wb_in        (wb_in),
    .rf_raddr     (rf_raddr),
    .rf_rdata     (rf_rdata),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  apb_ram #(
    .RAM_WORDS   (RAM_WORDS),
    .WAIT_CYCLES (WAIT_CYCLES)
  ) ram_inst (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .pstrb   (pstrb),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr)
  );

endmodule

//--- apb_ram.sv
`timescale 1ns/1ps

module apb_ram
  import lsu_pkg::*;
#(
  parameter int RAM_WORDS   = 256,
  parameter int WAIT_CYCLES = 1
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  psel,
  input  logic  penable,
  input  logic  pwrite,
  input  addr_t paddr,
  input  xlen_t pwdata,
  input  strb_t pstrb,
  output xlen_t prdata,
  output logic  pready,
  output logic  pslverr
);

  localparam int IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;
  localparam int CNT_W = (WAIT_CYCLES > 0) ? $clog2(WAIT_CYCLES + 1) : 1;

  xlen_t            mem [RAM_WORDS];
  logic [CNT_W-1:0] wait_cnt;
  logic [IDX_W-1:0] idx;
  logic             access;
  logic             out_of_range;
  logic             strb_ok;
  logic             err;

  assign access       = psel && penable;
  assign idx          = paddr[IDX_W+2:3];
  assign out_of_range = paddr[63:3] >= 61'(RAM_WORDS);

  // lanes must sit inside one naturally aligned unit
  always_comb begin
    case (pstrb)
      8'h01, 8'h02, 8'h04, 8'h08,
      8'h10, 8'h20, 8'h40, 8'h80: strb_ok = 1'b1;
      8'h03, 8'h0c, 8'h30, 8'hc0: strb_ok = 1'b1;
      8'h0f, 8'hf0, 8'hff:        strb_ok = 1'b1;
      default:                    strb_ok = 1'b0;
    endcase
  end

  assign err     = out_of_range || !strb_ok;
  assign pready  = (wait_cnt == CNT_W'(WAIT_CYCLES));
  assign pslverr = access && err;
  assign prdata  = out_of_range ? '0 : mem[idx];

  // counts access cycles spent with pready low
  always_ff @(posedge clk) begin
    if (rst) begin
      wait_cnt <= '0;
    end else if (access && !pready) begin
      wait_cnt <= wait_cnt + 1'b1;
    end else begin
      wait_cnt <= '0;
    end
  end

  always_ff @(posedge clk) begin
    if (access && pready && pwrite && !err) begin
      for (int b = 0; b < 8; b++) begin
        if (pstrb[b]) begin
          mem[idx][b*8 +: 8] <= pwdata[b*8 +: 8];
        end
      end
    end
  end

endmodule

//--- wb_stage.sv
`timescale 1ns/1ps

module wb_stage
  import lsu_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       wb_valid,
  input  mem_to_wb_t wb_in,
  input  reg_idx_t   rf_raddr,
  output xlen_t      rf_rdata,
  output logic       retire_valid,
  output mem_to_wb_t retire
);

  xlen_t      regs [32];
  logic       retire_valid_q;
  mem_to_wb_t retire_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_valid && wb_in.we) begin
      regs[wb_in.rd] <= wb_in.data;
    end
  end

  // x0 is hardwired to zero
  assign rf_rdata = (rf_raddr == '0) ? '0 : regs[rf_raddr];

  always_ff @(posedge clk) begin
    if (rst) begin
      retire_valid_q <= 1'b0;
    end else begin
      retire_valid_q <= wb_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (wb_valid) begin
      retire_q <= wb_in;
    end
  end

  assign retire_valid = retire_valid_q;
  assign retire       = retire_q;

endmodule

//--- mem_stage.sv
`timescale 1ns/1ps

module mem_stage
  import lsu_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        agu_valid,
  input  agu_to_mem_t agu_out,
  output logic        mem_allowin,
  output logic        wb_valid,
  output mem_to_wb_t  wb_in,
  output logic        psel,
  output logic        penable,
  output logic        pwrite,
  output addr_t       paddr,
  output xlen_t       pwdata,
  output strb_t       pstrb,
  input  xlen_t       prdata,
  input  logic        pready,
  input  logic        pslverr
);

  typedef enum logic [1:0] {IDLE, SETUP, ACCESS, DONE} state_t;

  state_t      state;
  state_t      state_nxt;
  agu_to_mem_t cmd_q;
  mem_to_wb_t  res_q;
  size_t       size;
  strb_t       size_mask;
  logic [2:0]  align_mask;
  logic        misaligned;
  logic        zero_ext;
  logic        accept;
  logic        finish;
  xlen_t       rd_shift;
  xlen_t       load_data;

  assign accept      = agu_valid && mem_allowin;
  assign finish      = (state == ACCESS) && pready;
  assign mem_allowin = (state == IDLE) || (state == DONE);
  assign wb_valid    = (state == DONE);
  assign wb_in       = res_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE:    state_nxt = accept ? SETUP : IDLE;
      SETUP:   state_nxt = ACCESS;
      ACCESS:  state_nxt = pready ? DONE : ACCESS;
      DONE:    state_nxt = accept ? SETUP : IDLE;
      default: state_nxt = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= agu_out;
    end
  end

  // size comes straight from the low opcode bits
  assign size     = cmd_q.op[1:0];
  assign zero_ext = cmd_q.op[2];

  always_comb begin
    case (size)
      SIZE_B: begin
        size_mask  = 8'h01;
        align_mask = 3'b000;
        pwdata     = {8{cmd_q.wdata[7:0]}};
      end
      SIZE_H: begin
        size_mask  = 8'h03;
        align_mask = 3'b001;
        pwdata     = {4{cmd_q.wdata[15:0]}};
      end
      SIZE_W: begin
        size_mask  = 8'h0f;
        align_mask = 3'b011;
        pwdata     = {2{cmd_q.wdata[31:0]}};
      end
      default: begin
        size_mask  = 8'hff;
        align_mask = 3'b111;
        pwdata     = cmd_q.wdata;
      end
    endcase
  end

  assign misaligned = |(cmd_q.addr[2:0] & align_mask);

  assign psel    = (state == SETUP) || (state == ACCESS);
  assign penable = (state == ACCESS);
  assign pwrite  = cmd_q.op[3];
  assign paddr   = {cmd_q.addr[63:3], 3'b000};
  // empty strobe tells the RAM the access is misaligned
  assign pstrb   = misaligned ? '0 : strb_t'(size_mask << cmd_q.addr[2:0]);

  assign rd_shift = prdata >> {cmd_q.addr[2:0], 3'b000};

  always_comb begin
    case (size)
      SIZE_B:  load_data = zero_ext ? {56'd0, rd_shift[7:0]} :
                                      {{56{rd_shift[7]}}, rd_shift[7:0]};
      SIZE_H:  load_data = zero_ext ? {48'd0, rd_shift[15:0]} :
                                      {{48{rd_shift[15]}}, rd_shift[15:0]};
      SIZE_W:  load_data = zero_ext ? {32'd0, rd_shift[31:0]} :
                                      {{32{rd_shift[31]}}, rd_shift[31:0]};
      default: load_data = rd_shift;
    endcase
  end

  always_ff @(posedge clk) begin
    if (finish) begin
      res_q.rd   <= cmd_q.rd;
      res_q.we   <= !pwrite && (cmd_q.rd != '0) && !pslverr;
      res_q.data <= (!pwrite && !pslverr) ? load_data : '0;
      res_q.err  <= pslverr;
    end
  end

endmodule

//--- agu_stage.sv
`timescale 1ns/1ps

module agu_stage
  import lsu_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        cmd_valid,
  input  mem_cmd_t    cmd,
  input  logic        mem_allowin,
  output logic        cmd_ready,
  output logic        agu_valid,
  output agu_to_mem_t agu_out
);

  logic        valid_q;
  agu_to_mem_t out_q;
  addr_t       offset_ext;

  // empty, or the held entry leaves on this edge
  assign cmd_ready = !valid_q || mem_allowin;
  assign agu_valid = valid_q;
  assign agu_out   = out_q;

  assign offset_ext = {{52{cmd.offset[11]}}, cmd.offset};

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (cmd_ready) begin
      valid_q <= cmd_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_valid && cmd_ready) begin
      out_q.op    <= cmd.op;
      out_q.addr  <= cmd.base + offset_ext;
      out_q.wdata <= cmd.wdata;
      out_q.rd    <= cmd.rd;
    end
  end

endmodule

//--- lsu_pkg.sv
package lsu_pkg;

  typedef logic [63:0]        xlen_t;
  typedef logic [63:0]        addr_t;
  typedef logic [4:0]         reg_idx_t;
  typedef logic [3:0]         mem_op_t;
  typedef logic [1:0]         size_t;
  typedef logic [7:0]         strb_t;
  typedef logic signed [11:0] offset_t;

  // op[3] store, op[2] zero-extend, op[1:0] access size
  localparam mem_op_t OP_LB  = 4'b0000;
  localparam mem_op_t OP_LH  = 4'b0001;
  localparam mem_op_t OP_LW  = 4'b0010;
  localparam mem_op_t OP_LD  = 4'b0011;
  localparam mem_op_t OP_LBU = 4'b0100;
  localparam mem_op_t OP_LHU = 4'b0101;
  localparam mem_op_t OP_LWU = 4'b0110;
  localparam mem_op_t OP_SB  = 4'b1000;
  localparam mem_op_t OP_SH  = 4'b1001;
  localparam mem_op_t OP_SW  = 4'b1010;
  localparam mem_op_t OP_SD  = 4'b1011;

  // 1, 2, 4 and 8 bytes
  localparam size_t SIZE_B = 2'd0;
  localparam size_t SIZE_H = 2'd1;
  localparam size_t SIZE_W = 2'd2;
  localparam size_t SIZE_D = 2'd3;

  // command as it enters the pipeline
  typedef struct packed {
    mem_op_t  op;
    xlen_t    base;
    offset_t  offset;
    xlen_t    wdata;
    reg_idx_t rd;
  } mem_cmd_t;

  typedef struct packed {
    mem_op_t  op;
    addr_t    addr;
    xlen_t    wdata;
    reg_idx_t rd;
  } agu_to_mem_t;

  // also the retire report at the top
  typedef struct packed {
    reg_idx_t rd;
    logic     we;
    xlen_t    data;
    logic     err;
  } mem_to_wb_t;

endpackage
